// File: verilog/scan_pkg.sv
// Shared definitions for the packet string scanner
// Window geometry and the collector state encoding

package scan_pkg;

  // Bytes carried by one input word
  localparam int WORD_BYTES = 4;

  // Longest flagged string
  localparam int MAX_PAT_LEN = 17;

  // Enough history to test every alignment of the newest word
  localparam int WINDOW_BYTES = MAX_PAT_LEN + WORD_BYTES - 1;

  // Width of a pattern length field
  localparam int LEN_W = 5;

  // Collector FSM states
  typedef enum logic [1:0] {
    COL_IDLE   = 2'd0,
    COL_SCAN   = 2'd1,
    COL_DRAIN  = 2'd2,
    COL_REPORT = 2'd3
  } collector_state_t;

endpackage

// File: verilog/window_buffer.sv
// Byte window for the string scanner
// Shifts each accepted word into a 20-byte window, newest byte at index 0,
// and passes the stream out again four words later

module window_buffer (
  input  logic                                    clk,
  input  logic                                    n_rst,
  input  logic                                    sof,
  input  logic                                    word_valid,
  input  logic [31:0]                             data_in,
  output logic [scan_pkg::WINDOW_BYTES-1:0][7:0]  window,
  output logic                                    window_update,
  output logic [31:0]                             data_out,
  output logic                                    out_valid
);
  import scan_pkg::*;

  // Words that fit behind the newest one
  localparam int FILL_WORDS = WINDOW_BYTES / WORD_BYTES - 1;
  localparam int CNT_W = $clog2(FILL_WORDS + 1);

  logic [CNT_W-1:0] word_cnt;
  logic             window_full;

  // Oldest word slot holds real packet data
  assign window_full = (word_cnt == CNT_W'(FILL_WORDS));

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      window        <= '0;
      window_update <= 1'b0;
      out_valid     <= 1'b0;
      word_cnt      <= '0;
    end else if (sof) begin
      window        <= '0;
      window_update <= 1'b0;
      out_valid     <= 1'b0;
      word_cnt      <= '0;
    end else begin
      window_update <= word_valid;
      out_valid     <= word_valid && window_full;
      if (word_valid) begin
        // Earliest byte data_in[31:24] lands at index 3
        window <= {window[WINDOW_BYTES-WORD_BYTES-1:0], data_in};
        if (!window_full) begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // Oldest word in the window is the one taken four words ago
  assign data_out = window[WINDOW_BYTES-1 -: WORD_BYTES];

endmodule

// File: verilog/pattern_matcher.sv
// Single flagged-string matcher
// Compares its stored string against the byte window at all four alignments
// of the newest word; the hit flag holds until the next packet starts

module pattern_matcher (
  input  logic                                    clk,
  input  logic                                    n_rst,
  input  logic                                    sof,
  input  logic                                    window_update,
  input  logic [scan_pkg::WINDOW_BYTES-1:0][7:0]  window,
  input  logic                                    pattern_we,
  input  logic [scan_pkg::LEN_W-1:0]              pattern_len,
  input  logic [scan_pkg::MAX_PAT_LEN-1:0][7:0]   pattern_chars,
  output logic                                    hit
);
  import scan_pkg::*;

  logic [MAX_PAT_LEN-1:0][7:0] pat_chars;
  logic [LEN_W-1:0]            pat_len;

  // Window bytes filled by this packet, not counting the newest word
  logic [WINDOW_BYTES-1:0]     fill_mask;
  logic [WINDOW_BYTES-1:0]     byte_valid;
  logic [WORD_BYTES-1:0]       align_hit;

  assign byte_valid = {fill_mask[WINDOW_BYTES-WORD_BYTES-1:0], {WORD_BYTES{1'b1}}};

  // String bytes only change on a load
  always_ff @(posedge clk) begin
    if (pattern_we) begin
      pat_chars <= pattern_chars;
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      pat_len <= '0;
    end else if (pattern_we) begin
      pat_len <= pattern_len;
    end
  end

  // Alignment a puts the last string byte at window[a]
  always_comb begin
    for (int a = 0; a < WORD_BYTES; a++) begin
      // Empty string never matches
      align_hit[a] = (pat_len != '0);
      for (int j = 0; j < MAX_PAT_LEN; j++) begin
        // Bytes below the string start are don't-care
        if (j + int'(pat_len) >= MAX_PAT_LEN) begin
          if (!byte_valid[a + MAX_PAT_LEN - 1 - j] ||
              window[a + MAX_PAT_LEN - 1 - j] != pat_chars[j]) begin
            align_hit[a] = 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      fill_mask <= '0;
      hit       <= 1'b0;
    end else if (sof) begin
      fill_mask <= '0;
      hit       <= 1'b0;
    end else if (window_update) begin
      fill_mask <= byte_valid;
      if (|align_hit) begin
        hit <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/match_collector.sv
// Verdict collector
// Tracks the packet from sof to eop, lets the last hit bits settle,
// then reports which patterns were seen and the lowest one that hit

module match_collector #(
  parameter int NUM_PATTERNS = 4,
  parameter int PAT_SEL_W    = 2
) (
  input  logic                    clk,
  input  logic                    n_rst,
  input  logic                    sof,
  input  logic                    word_valid,
  input  logic                    eop,
  input  logic [NUM_PATTERNS-1:0] hits,
  output logic                    verdict_valid,
  output logic [NUM_PATTERNS-1:0] verdict_hits,
  output logic                    verdict_any,
  output logic [PAT_SEL_W-1:0]    verdict_first,
  output logic                    busy
);
  import scan_pkg::*;

  collector_state_t     state;
  collector_state_t     next_state;
  logic                 last_word;
  logic [PAT_SEL_W-1:0] first_idx;

  assign last_word = word_valid && eop;

  always_comb begin
    next_state = state;
    case (state)
      COL_IDLE: begin
        if (sof) begin
          next_state = COL_SCAN;
        end
      end
      COL_SCAN: begin
        if (last_word) begin
          next_state = COL_DRAIN;
        end
      end
      // One cycle for the matchers to see the last word
      COL_DRAIN:  next_state = COL_REPORT;
      COL_REPORT: next_state = COL_IDLE;
      default:    next_state = COL_IDLE;
    endcase
  end

  // Lowest set index wins, zero when nothing hit
  always_comb begin
    first_idx = '0;
    for (int i = NUM_PATTERNS - 1; i >= 0; i--) begin
      if (hits[i]) begin
        first_idx = PAT_SEL_W'(i);
      end
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state         <= COL_IDLE;
      verdict_valid <= 1'b0;
    end else begin
      state         <= next_state;
      verdict_valid <= (state == COL_REPORT);
    end
  end

  always_ff @(posedge clk) begin
    if (state == COL_REPORT) begin
      verdict_hits  <= hits;
      verdict_any   <= |hits;
      verdict_first <= first_idx;
    end
  end

  assign busy = (state != COL_IDLE);

endmodule

// File: verilog/string_scanner.sv
// Packet string scanner top level
// One shared byte window feeds a bank of pattern matchers; the collector
// turns their flags into a per-packet verdict three cycles after eop

module string_scanner #(
  parameter int NUM_PATTERNS = 4,
  parameter int PAT_SEL_W    = (NUM_PATTERNS > 1) ? $clog2(NUM_PATTERNS) : 1
) (
  input  logic                                   clk,
  input  logic                                   n_rst,
  input  logic                                   sof,
  input  logic                                   eop,
  input  logic                                   word_valid,
  input  logic [31:0]                            data_in,
  input  logic                                   pattern_we,
  input  logic [PAT_SEL_W-1:0]                   pattern_sel,
  input  logic [scan_pkg::LEN_W-1:0]             pattern_len,
  input  logic [scan_pkg::MAX_PAT_LEN-1:0][7:0]  pattern_chars,
  output logic [31:0]                            data_out,
  output logic                                   out_valid,
  output logic                                   verdict_valid,
  output logic [NUM_PATTERNS-1:0]                verdict_hits,
  output logic                                   verdict_any,
  output logic [PAT_SEL_W-1:0]                   verdict_first,
  output logic                                   busy
);
  import scan_pkg::*;

  logic [WINDOW_BYTES-1:0][7:0] window;
  logic                         window_update;
  logic [NUM_PATTERNS-1:0]      hits;

  window_buffer window_buffer_inst (
    .clk           (clk),
    .n_rst         (n_rst),
    .sof           (sof),
    .word_valid    (word_valid),
    .data_in       (data_in),
    .window        (window),
    .window_update (window_update),
    .data_out      (data_out),
    .out_valid     (out_valid)
  );

  for (genvar g = 0; g < NUM_PATTERNS; g++) begin : g_match
    pattern_matcher pattern_matcher_inst (
      .clk           (clk),
      .n_rst         (n_rst),
      .sof           (sof),
      .window_update (window_update),
      .window        (window),
      .pattern_we    (pattern_we && (pattern_sel == PAT_SEL_W'(g))),
      .pattern_len   (pattern_len),
      .pattern_chars (pattern_chars),
      .hit           (hits[g])
    );
  end

  match_collector #(
    .NUM_PATTERNS (NUM_PATTERNS),
    .PAT_SEL_W    (PAT_SEL_W)
  ) match_collector_inst (
    .clk           (clk),
    .n_rst         (n_rst),
    .sof           (sof),
    .word_valid    (word_valid),
    .eop           (eop),
    .hits          (hits),
    .verdict_valid (verdict_valid),
    .verdict_hits  (verdict_hits),
    .verdict_any   (verdict_any),
    .verdict_first (verdict_first),
    .busy          (busy)
  );

endmodule

// File: verification/string_scanner_assertions.sv
// Protocol checks on the verdict collector
// Bound into match_collector to watch the verdict pulse and its latency

module string_scanner_assertions (
  input logic                         clk,
  input logic                         n_rst,
  input logic                         sof,
  input logic                         word_valid,
  input logic                         eop,
  input logic                         verdict_valid,
  input logic                         busy,
  input scan_pkg::collector_state_t   state
);
  import scan_pkg::*;

  // Single-cycle verdict pulse
  verdict_pulse: assert property (@(posedge clk) disable iff (!n_rst)
    verdict_valid |=> !verdict_valid)
    else $error("verdict_valid held for more than one cycle");

  // Verdict only three cycles after an eop word
  verdict_after_eop: assert property (@(posedge clk) disable iff (!n_rst)
    verdict_valid |-> $past(state == COL_SCAN && word_valid && eop, 3))
    else $error("verdict_valid without an eop word three cycles earlier");

  eop_gives_verdict: assert property (@(posedge clk) disable iff (!n_rst)
    $past(state == COL_SCAN && word_valid && eop, 3) |-> verdict_valid)
    else $error("no verdict_valid three cycles after the eop word");

  // Next packet waits for the report
  no_early_sof: assert property (@(posedge clk) disable iff (!n_rst)
    (state == COL_DRAIN || state == COL_REPORT) |-> !sof)
    else $error("sof arrived while the collector was draining or reporting");

  idle_after_reset: assert property (@(posedge clk)
    $rose(n_rst) |-> !busy)
    else $error("busy high right after reset");

endmodule

// File: verification/tb_string_scanner.sv
// Testbench for the packet string scanner
// Seeded random packets and patterns, checked against a byte-list model
// of each packet and a queue of the accepted words

module tb_string_scanner;
  import scan_pkg::*;

  localparam int NUM_PATTERNS = 4;
  localparam int PAT_SEL_W = 2;
  localparam int CLK_PERIOD = 8;
  localparam int SEED = 83787;
  localparam int MAX_WORDS = 16;
  localparam int VERDICT_LATENCY = 3;
  localparam int TOTAL_PACKETS = 64;
  // sof, every word with one gap, verdict wait and a share of pattern loads
  localparam int PACKET_CYCLES = 1 + 2 * MAX_WORDS + VERDICT_LATENCY + 10;
  localparam int WATCHDOG_TIME = (TOTAL_PACKETS * PACKET_CYCLES + 20) * CLK_PERIOD * 4;

  logic                        clk;
  logic                        n_rst;
  logic                        sof;
  logic                        eop;
  logic                        word_valid;
  logic [31:0]                 data_in;
  logic                        pattern_we;
  logic [PAT_SEL_W-1:0]        pattern_sel;
  logic [LEN_W-1:0]            pattern_len;
  logic [MAX_PAT_LEN-1:0][7:0] pattern_chars;
  logic [31:0]                 data_out;
  logic                        out_valid;
  logic                        verdict_valid;
  logic [NUM_PATTERNS-1:0]     verdict_hits;
  logic                        verdict_any;
  logic [PAT_SEL_W-1:0]        verdict_first;
  logic                        busy;

  // Reference model state
  logic [7:0]              pat_str [NUM_PATTERNS][MAX_PAT_LEN];
  int                      pat_len_m [NUM_PATTERNS];
  logic [7:0]              pkt_bytes [$];
  logic [31:0]             sent_words [$];
  int                      out_idx;
  logic [NUM_PATTERNS-1:0] last_hits;

  int    checks;
  int    errors;
  int    base_checks;
  int    base_errors;
  string test_name;

  string_scanner #(
    .NUM_PATTERNS (NUM_PATTERNS),
    .PAT_SEL_W    (PAT_SEL_W)
  ) string_scanner_inst (
    .clk           (clk),
    .n_rst         (n_rst),
    .sof           (sof),
    .eop           (eop),
    .word_valid    (word_valid),
    .data_in       (data_in),
    .pattern_we    (pattern_we),
    .pattern_sel   (pattern_sel),
    .pattern_len   (pattern_len),
    .pattern_chars (pattern_chars),
    .data_out      (data_out),
    .out_valid     (out_valid),
    .verdict_valid (verdict_valid),
    .verdict_hits  (verdict_hits),
    .verdict_any   (verdict_any),
    .verdict_first (verdict_first),
    .busy          (busy)
  );

  bind match_collector string_scanner_assertions collector_checks (
    .clk           (clk),
    .n_rst         (n_rst),
    .sof           (sof),
    .word_valid    (word_valid),
    .eop           (eop),
    .verdict_valid (verdict_valid),
    .busy          (busy),
    .state         (state)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    base_checks = checks;
    base_errors = errors;
  endtask

  task automatic end_test();
    $display("%s: %0d checks, %0d errors", test_name, checks - base_checks,
             errors - base_errors);
  endtask

  // Each out_valid word should be the accepted word four places back
  always @(negedge clk) begin
    if (n_rst && out_valid) begin
      if (out_idx >= sent_words.size()) begin
        $display("Error in %s: out_valid with no accepted word four places back", test_name);
        errors++;
      end else begin
        compare({test_name, " data_out"}, sent_words[out_idx], data_out);
      end
      out_idx++;
    end
  end

  // Last string byte goes to the top byte of pattern_chars
  task automatic write_pattern(input int p);
    logic [MAX_PAT_LEN-1:0][7:0] chars;
    for (int i = 0; i < MAX_PAT_LEN; i++) begin
      chars[i] = 8'($urandom);
    end
    for (int i = 0; i < pat_len_m[p]; i++) begin
      chars[MAX_PAT_LEN - pat_len_m[p] + i] = pat_str[p][i];
    end
    @(negedge clk);
    pattern_we = 1'b1;
    pattern_sel = PAT_SEL_W'(p);
    pattern_len = LEN_W'(pat_len_m[p]);
    pattern_chars = chars;
    @(negedge clk);
    pattern_we = 1'b0;
  endtask

  task automatic random_pattern(input int p, input int len);
    pat_len_m[p] = len;
    for (int i = 0; i < MAX_PAT_LEN; i++) begin
      pat_str[p][i] = 8'($urandom);
    end
    write_pattern(p);
  endtask

  task automatic new_packet(input int n_words);
    pkt_bytes.delete();
    for (int i = 0; i < 4 * n_words; i++) begin
      pkt_bytes.push_back(8'($urandom));
    end
  endtask

  task automatic plant(input int p, input int offset);
    for (int i = 0; i < pat_len_m[p]; i++) begin
      pkt_bytes[offset + i] = pat_str[p][i];
    end
  endtask

  // Hit when the string appears as a contiguous run anywhere in the packet
  function automatic logic model_hit(input int p);
    logic found;
    logic same;
    found = 1'b0;
    for (int s = 0; s + pat_len_m[p] <= pkt_bytes.size(); s++) begin
      same = 1'b1;
      for (int i = 0; i < pat_len_m[p]; i++) begin
        if (pkt_bytes[s + i] !== pat_str[p][i]) begin
          same = 1'b0;
        end
      end
      if (same) begin
        found = 1'b1;
      end
    end
    return found && (pat_len_m[p] > 0);
  endfunction

  task automatic run_packet(input int gap_pct);
    logic [NUM_PATTERNS-1:0] exp_hits;
    logic [PAT_SEL_W-1:0]    exp_first;
    logic                    first_found;
    int                      n_words;
    int                      wait_cycles;
    exp_hits = '0;
    exp_first = '0;
    first_found = 1'b0;
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      exp_hits[p] = model_hit(p);
      if (exp_hits[p] && !first_found) begin
        exp_first = PAT_SEL_W'(p);
        first_found = 1'b1;
      end
    end
    n_words = pkt_bytes.size() / 4;
    last_hits = '0;
    @(negedge clk);
    sof = 1'b1;
    sent_words.delete();
    out_idx = 0;
    for (int w = 0; w < n_words; w++) begin
      @(negedge clk);
      if (w == 0) begin
        compare({test_name, " busy in packet"}, 32'd1, 32'(busy));
      end
      sof = 1'b0;
      word_valid = 1'b0;
      eop = 1'b0;
      if (int'($urandom_range(99)) < gap_pct) begin
        @(negedge clk);
      end
      word_valid = 1'b1;
      data_in = {pkt_bytes[4*w], pkt_bytes[4*w+1], pkt_bytes[4*w+2], pkt_bytes[4*w+3]};
      eop = (w == n_words - 1);
      sent_words.push_back(data_in);
    end
    wait_cycles = 0;
    do begin
      @(negedge clk);
      word_valid = 1'b0;
      eop = 1'b0;
      wait_cycles++;
    end while (!verdict_valid && wait_cycles < 2 * VERDICT_LATENCY + 2);
    if (!verdict_valid) begin
      $display("Error in %s: no verdict within %0d cycles after eop", test_name, wait_cycles);
      errors++;
    end else begin
      last_hits = verdict_hits;
      compare({test_name, " latency"}, 32'(VERDICT_LATENCY), 32'(wait_cycles));
      compare({test_name, " verdict_hits"}, 32'(exp_hits), 32'(verdict_hits));
      compare({test_name, " verdict_any"}, 32'(|exp_hits), 32'(verdict_any));
      compare({test_name, " verdict_first"}, 32'(exp_first), 32'(verdict_first));
      compare({test_name, " busy after verdict"}, 32'd0, 32'(busy));
    end
    compare({test_name, " out words"}, 32'((n_words > 4) ? n_words - 4 : 0), 32'(out_idx));
  endtask

  initial begin
    int                      pick;
    int                      n_plant;
    logic [NUM_PATTERNS-1:0] planted;
    void'($urandom(SEED));
    clk = 1'b0;
    n_rst = 1'b0;
    sof = 1'b0;
    eop = 1'b0;
    word_valid = 1'b0;
    data_in = '0;
    pattern_we = 1'b0;
    pattern_sel = '0;
    pattern_len = '0;
    pattern_chars = '0;
    checks = 0;
    errors = 0;
    out_idx = 0;
    last_hits = '0;
    repeat (8) @(negedge clk);
    n_rst = 1'b1;

    start_test("reset");
    compare("reset verdict_valid", 32'd0, 32'(verdict_valid));
    compare("reset out_valid", 32'd0, 32'(out_valid));
    compare("reset busy", 32'd0, 32'(busy));
    end_test();

    start_test("planted_match");
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      random_pattern(p, 1 + int'($urandom_range(MAX_PAT_LEN - 1)));
    end
    for (int k = 0; k < 12; k++) begin
      pick = int'($urandom_range(NUM_PATTERNS - 1));
      new_packet(5 + int'($urandom_range(MAX_WORDS - 5)));
      plant(pick, int'($urandom_range(pkt_bytes.size() - pat_len_m[pick])));
      run_packet(20);
      compare({test_name, " planted bit"}, 32'd1, 32'(last_hits[pick]));
    end
    end_test();

    start_test("alignment_edges");
    random_pattern(0, 17);
    random_pattern(1, 1);
    random_pattern(2, 5);
    random_pattern(3, 12);
    for (int o = 0; o < 4; o++) begin
      for (int p = 0; p < NUM_PATTERNS; p++) begin
        new_packet(8);
        plant(p, 8 + o);
        run_packet(0);
        compare({test_name, " planted bit"}, 32'd1, 32'(last_hits[p]));
      end
    end
    // String ending in the last byte of the packet
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      new_packet(8);
      plant(p, 32 - pat_len_m[p]);
      run_packet(0);
      compare({test_name, " tail bit"}, 32'd1, 32'(last_hits[p]));
    end
    end_test();

    start_test("clear_between_packets");
    for (int k = 0; k < 4; k++) begin
      new_packet(MAX_WORDS);
      plant(0, 3);
      plant(3, 30 + k);
      plant(2, 50);
      run_packet(10);
      compare({test_name, " matching packet"}, 32'hd, 32'(last_hits & 4'b1101));
      // Clean packet right after the matching one
      new_packet(MAX_WORDS);
      run_packet(10);
    end
    end_test();

    start_test("delayed_stream");
    for (int k = 0; k < 6; k++) begin
      new_packet(1 + int'($urandom_range(MAX_WORDS - 1)));
      run_packet(50);
    end
    end_test();

    start_test("several_patterns");
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      random_pattern(p, 1 + int'($urandom_range(MAX_PAT_LEN - 1)));
    end
    for (int k = 0; k < 8; k++) begin
      pick = int'($urandom_range(NUM_PATTERNS - 1));
      n_plant = 2 + int'($urandom_range(1));
      planted = '0;
      new_packet(MAX_WORDS);
      for (int j = 0; j < n_plant; j++) begin
        planted[(pick + j) % NUM_PATTERNS] = 1'b1;
        plant((pick + j) % NUM_PATTERNS,
              20 * j + int'($urandom_range(20 - pat_len_m[(pick + j) % NUM_PATTERNS])));
      end
      run_packet(20);
      compare({test_name, " planted bits"}, 32'(planted), 32'(last_hits & planted));
    end
    end_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Bound from the packet count and the longest packet
  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: tests still running after %0d time units", WATCHDOG_TIME);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: filelist.f
verilog/scan_pkg.sv
verilog/window_buffer.sv
verilog/pattern_matcher.sv
verilog/match_collector.sv
verilog/string_scanner.sv
verification/string_scanner_assertions.sv
verification/tb_string_scanner.sv

// File: Makefile
# Verilator build and run for the packet string scanner

TOP = tb_string_scanner

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
